/* hdl/cam_pkg.sv */
package cam_pkg;

  ////////////////////////////////////////////////////////////
  // Host opcodes
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_IDLE       = 3'd0,  // Topology echo only
    OP_UPDATE_ALL = 3'd1,  // Bulk load of consecutive entries
    OP_SEARCH     = 3'd2,  // One key per beat
    OP_UPDATE_ONE = 3'd3   // Accepted, no effect
  } cam_op_t;

  ////////////////////////////////////////////////////////////
  // Beat geometry
  ////////////////////////////////////////////////////////////

  localparam int LANES  = 16;  // Entries carried per load beat
  localparam int LANE_W = 32;  // Entry and key width
  localparam int BEAT_W = LANES * LANE_W;

  typedef logic [LANE_W-1:0] lane_t;  // One entry or key
  typedef logic [BEAT_W-1:0] beat_t;  // Full 512-bit stream beat

  ////////////////////////////////////////////////////////////
  // Fixed codes
  ////////////////////////////////////////////////////////////

  localparam lane_t TOPOLOGY_CODE    = 32'd4;    // Low word asking for echo
  localparam lane_t UPDATE_DONE_CODE = 32'd100;  // Payload of the done word

endpackage : cam_pkg

/* hdl/cam_load_if.sv */
`timescale 1ns/1ns

// Write and search strobes from control to the entry array.
// Everything is qualified by its strobe in the same cycle.
interface cam_load_if #(
  parameter int IDX_W = 6
);

  logic                  wr_en;     // One load beat this cycle
  logic [IDX_W-1:0]      wr_base;   // First entry of the beat
  cam_pkg::beat_t        wr_data;   // Sixteen lanes, lane 0 in the low word
  logic                  srch_en;   // One search key this cycle
  cam_pkg::lane_t        srch_key;  // Key from the low word

  modport ctrl (
    output wr_en,
    output wr_base,
    output wr_data,
    output srch_en,
    output srch_key
  );

  modport array (
    input wr_en,
    input wr_base,
    input wr_data,
    input srch_en,
    input srch_key
  );

endinterface : cam_load_if

/* hdl/cam_control.sv */
`timescale 1ns/1ns

module cam_control #(
  parameter int CAM_SIZE = 64,
  parameter int IDX_W    = 6
) (
  input  logic             aclk,
  input  logic             areset,
  input  cam_pkg::cam_op_t state,
  input  logic [31:0]      update_num,
  input  logic             s_tvalid,
  input  cam_pkg::beat_t   s_tdata,
  cam_load_if.ctrl         load,
  output logic             done_pulse,
  output logic             echo_pulse,
  output cam_pkg::beat_t   echo_data
);

  ////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////

  logic             load_beat;   // Accepted bulk load beat
  logic             srch_beat;   // Accepted search beat
  logic             idle_beat;   // Accepted beat while idle
  logic [IDX_W-1:0] wr_ptr;      // Base entry of the next load beat
  logic [31:0]      last_base;   // Base of beat update_num-1
  logic             last_beat;   // Pointer sits on the final programmed beat
  logic             at_end;      // Pointer sits on the last array slot
  logic             wrap;        // This load beat returns the pointer to 0

  assign load_beat = s_tvalid && (state == cam_pkg::OP_UPDATE_ALL);
  assign srch_beat = s_tvalid && (state == cam_pkg::OP_SEARCH);
  assign idle_beat = s_tvalid && (state == cam_pkg::OP_IDLE);
  // OP_UPDATE_ONE and unused codes fall through with no strobe

  ////////////////////////////////////////////////////////////
  // Load pointer and wrap
  ////////////////////////////////////////////////////////////

  assign last_base = (update_num - 32'd1) * cam_pkg::LANES;  // Beats are LANES apart
  assign last_beat = (32'(wr_ptr) == last_base);
  assign at_end    = (wr_ptr == IDX_W'(CAM_SIZE - cam_pkg::LANES));  // Never run past the array
  assign wrap      = last_beat || at_end;

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
    end else if (load_beat) begin
      if (wrap) begin
        wr_ptr <= '0;                                  // Next load restarts at entry 0
      end else begin
        wr_ptr <= wr_ptr + IDX_W'(cam_pkg::LANES);     // Step one beat of lanes
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Strobes to the array and result stage
  ////////////////////////////////////////////////////////////

  assign load.wr_en    = load_beat;
  assign load.wr_base  = wr_ptr;                                   // Base of the current beat
  assign load.wr_data  = s_tdata;
  assign load.srch_en  = srch_beat;
  assign load.srch_key = s_tdata[cam_pkg::LANE_W-1:0];             // Key lives in the low word

  assign done_pulse = load_beat && wrap;       // Result stage registers it
  assign echo_pulse = idle_beat && (s_tdata[cam_pkg::LANE_W-1:0] == cam_pkg::TOPOLOGY_CODE);
  assign echo_data  = s_tdata;                 // Returned unchanged

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Pointer holds below the array size across any sequence of loads
  ptr_in_range_a : assert property (
    @(posedge aclk) disable iff (areset) 32'(wr_ptr) < CAM_SIZE
  ) else $error("Load pointer %0d outside the entry array", wr_ptr);

  // Array never sees a write and a search in one cycle
  wr_srch_excl_a : assert property (
    @(posedge aclk) disable iff (areset) !(load.wr_en && load.srch_en)
  ) else $error("Write and search strobed together");

endmodule : cam_control

/* hdl/cam_entry_array.sv */
`timescale 1ns/1ns

module cam_entry_array #(
  parameter int CAM_SIZE = 64,
  parameter int IDX_W    = 6
) (
  input  logic                aclk,
  input  logic                areset,
  cam_load_if.array           load,
  output logic [CAM_SIZE-1:0] match_vec,
  output logic                match_valid
);

  localparam int LANE_BITS = $clog2(cam_pkg::LANES);

  ////////////////////////////////////////////////////////////
  // Search stage 1, key register
  ////////////////////////////////////////////////////////////

  cam_pkg::lane_t      key_q;   // Key under compare
  logic                key_vld; // Stage 1 valid
  logic [CAM_SIZE-1:0] hit;     // Per-entry equality, combinational

  always_ff @(posedge aclk) begin
    if (areset) begin
      key_vld <= 1'b0;
    end else begin
      key_vld <= load.srch_en;
    end
  end

  always_ff @(posedge aclk) begin
    if (load.srch_en) begin
      key_q <= load.srch_key;  // Held between searches
    end
  end

  ////////////////////////////////////////////////////////////
  // Entry slots
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < CAM_SIZE; i++) begin : g_entry
    localparam int LANE = i % cam_pkg::LANES;   // Lane of the beat that feeds this slot
    localparam int BASE = i - LANE;             // Beat base that owns this slot

    cam_pkg::lane_t entry_q;

    always_ff @(posedge aclk) begin
      if (load.wr_en && (load.wr_base == IDX_W'(BASE))) begin
        entry_q <= load.wr_data[LANE*cam_pkg::LANE_W +: cam_pkg::LANE_W];
      end
    end

    assign hit[i] = ~|(entry_q ^ key_q);  // XOR equals zero
  end : g_entry

  ////////////////////////////////////////////////////////////
  // Search stage 2, match vector
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      match_valid <= 1'b0;
    end else begin
      match_valid <= key_vld;
    end
  end

  always_ff @(posedge aclk) begin
    match_vec <= hit;  // Sampled every cycle, qualified by match_valid
  end

  // Control only hands out beat-aligned bases
  wr_base_aligned_a : assert property (
    @(posedge aclk) disable iff (areset)
    load.wr_en |-> (load.wr_base[LANE_BITS-1:0] == '0)
  ) else $error("Write base %0d not aligned to a beat", load.wr_base);

endmodule : cam_entry_array

/* hdl/cam_match_encoder.sv */
`timescale 1ns/1ns

module cam_match_encoder #(
  parameter int CAM_SIZE = 64,
  parameter int IDX_W    = 6
) (
  input  logic                aclk,
  input  logic                areset,
  input  logic [CAM_SIZE-1:0] match_vec,
  input  logic                match_valid,
  output logic [IDX_W:0]      match_index,
  output logic                index_valid
);

  localparam int HALF = CAM_SIZE / 2;

  ////////////////////////////////////////////////////////////
  // Lowest set bit of one half
  ////////////////////////////////////////////////////////////

  // Scans from the top so the lowest hit is written last
  function automatic logic [IDX_W:0] first_set(
    input logic [HALF-1:0] v,
    input int              base
  );
    logic [IDX_W:0] idx;
    idx = '1;  // Empty half
    for (int i = HALF - 1; i >= 0; i--) begin
      if (v[i]) begin
        idx = (IDX_W+1)'(base + i);
      end
    end
    return idx;
  endfunction

  logic [IDX_W:0] lo_idx;   // First hit in entries 0..HALF-1
  logic [IDX_W:0] hi_idx;   // First hit in entries HALF..CAM_SIZE-1
  logic           half_vld; // Stage 3 valid

  ////////////////////////////////////////////////////////////
  // Stage 3 registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      half_vld <= 1'b0;
    end else begin
      half_vld <= match_valid;
    end
  end

  always_ff @(posedge aclk) begin
    lo_idx <= first_set(match_vec[HALF-1:0], 0);
    hi_idx <= first_set(match_vec[CAM_SIZE-1:HALF], HALF);  // Offset into upper half
  end

  ////////////////////////////////////////////////////////////
  // Merge
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (lo_idx != '1) begin
      match_index = lo_idx;  // Lower half wins
    end else begin
      match_index = hi_idx;  // All ones when both halves are empty
    end
  end

  assign index_valid = half_vld;

endmodule : cam_match_encoder

/* hdl/cam_result_stage.sv */
`timescale 1ns/1ns

module cam_result_stage #(
  parameter int IDX_W = 6
) (
  input  logic           aclk,
  input  logic           areset,
  input  logic [IDX_W:0] match_index,
  input  logic           index_valid,
  input  logic           done_pulse,
  input  logic           echo_pulse,
  input  cam_pkg::beat_t echo_data,
  output logic           m_tvalid,
  output cam_pkg::beat_t m_tdata,
  output logic           update_all_end
);

  ////////////////////////////////////////////////////////////
  // Output strobes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      m_tvalid       <= 1'b0;
      update_all_end <= 1'b0;
    end else begin
      m_tvalid       <= index_valid || done_pulse || echo_pulse;  // One-cycle pulse
      update_all_end <= done_pulse;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output beat, search over done over echo
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (index_valid) begin
      m_tdata <= cam_pkg::beat_t'(match_index);                 // Zero-extended index
    end else if (done_pulse) begin
      m_tdata <= cam_pkg::beat_t'(cam_pkg::UPDATE_DONE_CODE);
    end else if (echo_pulse) begin
      m_tdata <= echo_data;                                     // Beat returned as is
    end
  end

  // Done flag always rides on a valid output beat
  end_has_valid_a : assert property (
    @(posedge aclk) disable iff (areset) update_all_end |-> m_tvalid
  ) else $error("update_all_end without m_tvalid");

endmodule : cam_result_stage

/* hdl/cam_search_top.sv */
`timescale 1ns/1ns

module cam_search_top #(
  parameter int CAM_SIZE = 64
) (
  input  logic         aclk,
  input  logic         areset,
  input  logic [31:0]  update_num,
  input  logic [2:0]   state,
  input  logic         s_tvalid,
  input  logic [511:0] s_tdata,
  output logic         m_tvalid,
  output logic [511:0] m_tdata,
  output logic         update_all_end
);

  localparam int IDX_W = $clog2(CAM_SIZE);

  if (CAM_SIZE % 32 != 0) begin : g_size_check
    $error("CAM_SIZE must be a multiple of 32");
  end

  ////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////

  cam_pkg::cam_op_t    op;           // Decoded host opcode
  logic [CAM_SIZE-1:0] match_vec;
  logic                match_valid;
  logic [IDX_W:0]      match_index;  // All ones for no match
  logic                index_valid;
  logic                done_pulse;
  logic                echo_pulse;
  cam_pkg::beat_t      echo_data;

  assign op = cam_pkg::cam_op_t'(state);

  cam_load_if #(.IDX_W(IDX_W)) load_if ();

  ////////////////////////////////////////////////////////////
  // Control and datapath
  ////////////////////////////////////////////////////////////

  cam_control #(
    .CAM_SIZE (CAM_SIZE),
    .IDX_W    (IDX_W)
  ) cam_control_inst (
    .aclk       (aclk),
    .areset     (areset),
    .state      (op),
    .update_num (update_num),
    .s_tvalid   (s_tvalid),
    .s_tdata    (s_tdata),
    .load       (load_if.ctrl),
    .done_pulse (done_pulse),
    .echo_pulse (echo_pulse),
    .echo_data  (echo_data)
  );

  cam_entry_array #(
    .CAM_SIZE (CAM_SIZE),
    .IDX_W    (IDX_W)
  ) cam_entry_array_inst (
    .aclk        (aclk),
    .areset      (areset),
    .load        (load_if.array),
    .match_vec   (match_vec),
    .match_valid (match_valid)
  );

  cam_match_encoder #(
    .CAM_SIZE (CAM_SIZE),
    .IDX_W    (IDX_W)
  ) cam_match_encoder_inst (
    .aclk        (aclk),
    .areset      (areset),
    .match_vec   (match_vec),
    .match_valid (match_valid),
    .match_index (match_index),
    .index_valid (index_valid)
  );

  cam_result_stage #(
    .IDX_W (IDX_W)
  ) cam_result_stage_inst (
    .aclk           (aclk),
    .areset         (areset),
    .match_index    (match_index),
    .index_valid    (index_valid),
    .done_pulse     (done_pulse),
    .echo_pulse     (echo_pulse),
    .echo_data      (echo_data),
    .m_tvalid       (m_tvalid),
    .m_tdata        (m_tdata),
    .update_all_end (update_all_end)
  );

endmodule : cam_search_top

/* dv/cam_search_tb.sv */
`timescale 1ns/1ns

module cam_search_tb;

  localparam int CAM_SIZE    = 64;
  localparam int IDX_W       = $clog2(CAM_SIZE);
  localparam int PERIOD      = 20;
  localparam int RESET_CYC   = 3;
  localparam int N_RAND      = 8;   // Random hits in the first search run
  localparam int SRCH_LAT    = 4;   // Drive negedge to sampled search result
  localparam int PULSE_LAT   = 1;   // Drive negedge to sampled done or echo
  localparam int N_BEATS     = 4 + N_RAND + 3 + 3 + 4 + 5;
  localparam int N_PHASES    = 6;
  localparam int DRAIN_CYC   = 10;  // Pipeline flush plus quiet window per phase
  localparam int WATCHDOG_NS = (RESET_CYC + N_BEATS + N_PHASES * DRAIN_CYC + 20) * PERIOD;

  logic           aclk;
  logic           areset;
  logic [31:0]    update_num;
  logic [2:0]     state;
  logic           s_tvalid;
  cam_pkg::beat_t s_tdata;
  logic           m_tvalid;
  cam_pkg::beat_t m_tdata;
  logic           update_all_end;

  integer         seed = 32'hc54b38fd;
  int             cyc  = 0;            // Rising edges since time zero
  cam_pkg::lane_t shadow [CAM_SIZE];   // Expected entry contents
  cam_pkg::beat_t exp_data [$];        // Pending outputs, oldest first
  logic           exp_end [$];
  int             exp_cycle [$];
  string          exp_name [$];

  cam_search_top #(
    .CAM_SIZE (CAM_SIZE)
  ) cam_search_top_inst (
    .aclk           (aclk),
    .areset         (areset),
    .update_num     (update_num),
    .state          (state),
    .s_tvalid       (s_tvalid),
    .s_tdata        (s_tdata),
    .m_tvalid       (m_tvalid),
    .m_tdata        (m_tdata),
    .update_all_end (update_all_end)
  );

  initial begin
    aclk = 1'b0;
    forever #(PERIOD / 2) aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cyc <= cyc + 1;
  end

  ////////////////////////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////////////////////////

  // Lowest entry equal to the key, all ones when none
  function automatic logic [IDX_W:0] first_match_ref(cam_pkg::lane_t key);
    logic [IDX_W:0] idx;
    logic           found;
    idx   = '1;
    found = 1'b0;
    for (int i = 0; i < CAM_SIZE; i++) begin
      if (!found && (shadow[i] == key)) begin
        idx   = (IDX_W + 1)'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  function automatic cam_pkg::beat_t random_beat();
    cam_pkg::beat_t b;
    for (int k = 0; k < cam_pkg::LANES; k++) begin
      b[k*cam_pkg::LANE_W +: cam_pkg::LANE_W] = $random(seed);
    end
    return b;
  endfunction

  task automatic check_value(string name, cam_pkg::beat_t expected, cam_pkg::beat_t actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  task automatic report_failure(string msg);
    $display("ERROR: %s at cycle %0d", msg, cyc);
    $display("TEST FAIL");
    $fatal(1, "%s", msg);
  endtask

  task automatic expect_output(string name, cam_pkg::beat_t data, logic end_flag, int at_cyc);
    exp_name.push_back(name);
    exp_data.push_back(data);
    exp_end.push_back(end_flag);
    exp_cycle.push_back(at_cyc);
  endtask

  // One accepted beat, driven on the falling edge
  task automatic drive_beat(logic [2:0] op, cam_pkg::beat_t data, output int drive_cyc);
    @(negedge aclk);
    state     = op;
    s_tvalid  = 1'b1;
    s_tdata   = data;
    drive_cyc = cyc;  // Accepted at the next rising edge
  endtask

  task automatic fill_random(int first, int count);
    for (int i = first; i < first + count; i++) begin
      shadow[i] = $random(seed);
    end
  endtask

  // Bulk load from entry 0, pointer wraps on the last beat
  task automatic load_from_shadow(int nbeats);
    cam_pkg::beat_t b;
    int             c;
    for (int n = 0; n < nbeats; n++) begin
      for (int k = 0; k < cam_pkg::LANES; k++) begin
        b[k*cam_pkg::LANE_W +: cam_pkg::LANE_W] = shadow[n*cam_pkg::LANES + k];
      end
      drive_beat(cam_pkg::OP_UPDATE_ALL, b, c);
      if (n == 0) begin
        update_num = nbeats;  // Same falling edge as the first beat
      end
      if (n == nbeats - 1) begin
        expect_output("done word", cam_pkg::beat_t'(cam_pkg::UPDATE_DONE_CODE), 1'b1,
                      c + PULSE_LAT);
      end
    end
  endtask

  task automatic search_key(string name, cam_pkg::lane_t key);
    cam_pkg::beat_t b;
    int             c;
    b = random_beat();                 // Upper lanes are ignored by the DUT
    b[cam_pkg::LANE_W-1:0] = key;
    drive_beat(cam_pkg::OP_SEARCH, b, c);
    expect_output(name, cam_pkg::beat_t'(first_match_ref(key)), 1'b0, c + SRCH_LAT);
  endtask

  // Only an idle beat with the topology code comes back
  task automatic echo_probe(string name, logic [2:0] op, cam_pkg::lane_t low);
    cam_pkg::beat_t b;
    int             c;
    b = random_beat();
    b[cam_pkg::LANE_W-1:0] = low;
    drive_beat(op, b, c);
    if ((op == cam_pkg::OP_IDLE) && (low == cam_pkg::TOPOLOGY_CODE)) begin
      expect_output(name, b, 1'b0, c + PULSE_LAT);
    end
  endtask

  task automatic drain_outputs();
    @(negedge aclk);
    s_tvalid = 1'b0;
    state    = cam_pkg::OP_IDLE;
    while (exp_data.size() != 0) begin
      @(negedge aclk);
    end
    repeat (4) @(negedge aclk);  // Quiet window catches stray outputs
  endtask

  ////////////////////////////////////////////////////////////
  // Output compare
  ////////////////////////////////////////////////////////////

  always @(negedge aclk) begin
    if (!areset) begin
      if (update_all_end && !m_tvalid) begin
        report_failure("update_all_end is high while m_tvalid is low");
      end
      if (m_tvalid) begin
        if (exp_data.size() == 0) begin
          report_failure("m_tvalid is high with no output expected");
        end else begin
          check_value({exp_name[0], " arrival cycle"}, cam_pkg::beat_t'(exp_cycle[0]),
                      cam_pkg::beat_t'(cyc));
          check_value(exp_name[0], exp_data[0], m_tdata);
          check_value({exp_name[0], " update_all_end"}, cam_pkg::beat_t'(exp_end[0]),
                      cam_pkg::beat_t'(update_all_end));
          void'(exp_name.pop_front());
          void'(exp_data.pop_front());
          void'(exp_end.pop_front());
          void'(exp_cycle.pop_front());
        end
      end else if ((exp_cycle.size() != 0) && (exp_cycle[0] <= cyc)) begin
        report_failure({"no output arrived for ", exp_name[0]});
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("TEST FAIL");
    $fatal(1, "Timeout");
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    cam_pkg::lane_t dup_key;
    cam_pkg::lane_t hi_key;
    cam_pkg::lane_t miss_key;
    int             idx;
    areset     = 1'b1;
    update_num = 32'd4;
    state      = cam_pkg::OP_IDLE;
    s_tvalid   = 1'b0;
    s_tdata    = '0;
    dup_key    = 32'ha5a5_0001;
    hi_key     = 32'h5a5a_0002;
    repeat (RESET_CYC) @(negedge aclk);
    areset = 1'b0;

    fill_random(0, CAM_SIZE);  // Full load with planted keys
    shadow[12] = dup_key;      // Lower half copy must win
    shadow[40] = dup_key;
    shadow[61] = dup_key;
    shadow[45] = hi_key;       // Upper half only
    load_from_shadow(4);
    drain_outputs();

    for (int i = 0; i < N_RAND; i++) begin  // Back to back searches
      idx = {$random(seed)} % CAM_SIZE;
      search_key("random entry", shadow[idx]);
    end
    search_key("duplicate key", dup_key);
    search_key("upper half key", hi_key);
    miss_key = 32'h0bad_f00d;
    while (first_match_ref(miss_key) != '1) begin
      miss_key = miss_key + 32'd1;
    end
    search_key("absent key", miss_key);
    drain_outputs();

    echo_probe("topology echo", cam_pkg::OP_IDLE, cam_pkg::TOPOLOGY_CODE);
    echo_probe("idle other word", cam_pkg::OP_IDLE, 32'd5);
    echo_probe("single update", cam_pkg::OP_UPDATE_ONE, cam_pkg::TOPOLOGY_CODE);
    drain_outputs();

    for (int r = 0; r < 2; r++) begin  // Second pass proves the wrap
      fill_random(0, 32);
      load_from_shadow(2);
      drain_outputs();
    end

    search_key("reloaded low entry", shadow[5]);
    search_key("reloaded low entry", shadow[20]);
    search_key("kept high entry", shadow[45]);
    search_key("kept high entry", shadow[63]);
    search_key("duplicate after reload", dup_key);
    drain_outputs();

    if (exp_data.size() == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      report_failure("outputs still pending at the end of the run");
    end
  end

endmodule : cam_search_tb

/* cam_search_top.f */
hdl/cam_pkg.sv
hdl/cam_load_if.sv
hdl/cam_control.sv
hdl/cam_entry_array.sv
hdl/cam_match_encoder.sv
hdl/cam_result_stage.sv
hdl/cam_search_top.sv
dv/cam_search_tb.sv
